// File: files.f
source/fixed_point_pkg.sv
source/stream_join_ctrl.sv
source/fixed_sum_cast.sv
source/output_slice_regs.sv
source/fixed_adder.sv
testbench/tb_fixed_adder.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fixed_adder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_fixed_adder -f files.f \
    -o tb_fixed_adder || { echo "Build failed"; exit 1; }
sim_out="$(./obj_dir/tb_fixed_adder)"
echo "$sim_out"
echo "$sim_out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

// File: testbench/tb_fixed_adder.sv
module tb_fixed_adder;

    timeunit 1ns;
    timeprecision 1ps;

    import fixed_point_pkg::*;

    localparam int lanes     = default_lanes;
    localparam int in_width  = default_in_width;
    localparam int in_frac   = default_in_frac;
    localparam int out_width = default_out_width;
    localparam int out_frac  = default_out_frac;

    localparam int clk_period      = 4;
    localparam int total_beats     = 2000;
    localparam int cycles_per_beat = 20;
    localparam int watchdog_ns     = total_beats * cycles_per_beat * clk_period;

    localparam logic signed [in_width-1:0] in_max = {1'b0, {(in_width-1){1'b1}}};
    localparam logic signed [in_width-1:0] in_min = {1'b1, {(in_width-1){1'b0}}};

    logic clk;
    logic reset;

    logic signed [in_width-1:0]  data_in_0 [lanes-1:0];
    logic                        data_in_0_valid;
    logic                        data_in_0_ready;
    logic signed [in_width-1:0]  data_in_1 [lanes-1:0];
    logic                        data_in_1_valid;
    logic                        data_in_1_ready;
    logic signed [out_width-1:0] data_out_0 [lanes-1:0];
    logic                        data_out_0_valid;
    logic                        data_out_0_ready;

    // Expected output lanes with the oldest first
    logic [out_width-1:0] expect_q [$];

    int pending_words = 0;
    int join_count    = 0;
    int out_count     = 0;
    int checks_done   = 0;
    int value_errors  = 0;
    int other_errors  = 0;

    fixed_adder #(
        .LANES    (lanes),
        .IN_WIDTH (in_width),
        .IN_FRAC  (in_frac),
        .OUT_WIDTH(out_width),
        .OUT_FRAC (out_frac)
    ) u_fixed_adder (
        .clk             (clk),
        .reset           (reset),
        .data_in_0       (data_in_0),
        .data_in_0_valid (data_in_0_valid),
        .data_in_0_ready (data_in_0_ready),
        .data_in_1       (data_in_1),
        .data_in_1_valid (data_in_1_valid),
        .data_in_1_ready (data_in_1_ready),
        .data_out_0      (data_out_0),
        .data_out_0_valid(data_out_0_valid),
        .data_out_0_ready(data_out_0_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks_done++;
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Reference cast widens, rounds half up or shifts left, then clamps
    function automatic logic [out_width-1:0] expected_lane(input logic signed [in_width-1:0] a,
                                                           input logic signed [in_width-1:0] b);
        longint sum;
        longint scaled;
        longint out_max;
        longint out_min;
        sum = longint'(a) + longint'(b);
        if (out_frac < in_frac) begin
            scaled = (sum + (longint'(1) << (in_frac - out_frac - 1))) >>> (in_frac - out_frac);
        end else begin
            scaled = sum <<< (out_frac - in_frac);
        end
        out_max = (longint'(1) << (out_width - 1)) - 1;
        out_min = -(longint'(1) << (out_width - 1));
        if (scaled > out_max) begin
            scaled = out_max;
        end else if (scaled < out_min) begin
            scaled = out_min;
        end
        return scaled[out_width-1:0];
    endfunction

    // Corner operands for limits and half-LSB rounding
    function automatic logic signed [in_width-1:0] pick_corner(input int sel);
        case (sel)
            0:       return in_max;
            1:       return in_min;
            2:       return in_width'(0);
            3:       return in_width'(1);
            4:       return in_width'(-1);
            5:       return in_width'(3);
            6:       return in_width'(-3);
            default: return in_max - in_width'(1);
        endcase
    endfunction

    task automatic load_word(input int side, input int index, input bit directed);
        logic signed [in_width-1:0] value;
        for (int i = 0; i < lanes; i++) begin
            if (directed && index == 0) begin
                value = in_max;
            end else if (directed && index == 1) begin
                value = in_min;
            end else if (directed) begin
                value = pick_corner(int'($urandom_range(7, 0)));
            end else begin
                value = in_width'($urandom);
            end
            if (side == 0) begin
                data_in_0[i] = value;
            end else begin
                data_in_1[i] = value;
            end
        end
    endtask

    // Each source holds its word until it transfers, then may offer the next
    task automatic run_phase(input int beats, input int valid_pct, input int ready_pct,
                             input bit directed);
        int sent_0;
        int sent_1;
        bit xfer_0;
        bit xfer_1;
        sent_0 = 0;
        sent_1 = 0;
        while (sent_0 < beats || sent_1 < beats) begin
            @(negedge clk);
            xfer_0 = data_in_0_valid && data_in_0_ready;
            xfer_1 = data_in_1_valid && data_in_1_ready;
            @(posedge clk);
            #1;
            if (xfer_0) begin
                sent_0++;
                data_in_0_valid = 1'b0;
            end
            if (xfer_1) begin
                sent_1++;
                data_in_1_valid = 1'b0;
            end
            if (!data_in_0_valid && sent_0 < beats && int'($urandom_range(99, 0)) < valid_pct) begin
                load_word(0, sent_0, directed);
                data_in_0_valid = 1'b1;
            end
            if (!data_in_1_valid && sent_1 < beats && int'($urandom_range(99, 0)) < valid_pct) begin
                load_word(1, sent_1, directed);
                data_in_1_valid = 1'b1;
            end
            data_out_0_ready = (int'($urandom_range(99, 0)) < ready_pct);
        end
    endtask

    // Sampled mid-cycle, where every port is settled for the next edge
    always @(negedge clk) begin : monitor
        logic [out_width-1:0] expected;
        if (!reset) begin
            check_value("data_in_0_ready", 32'(data_in_0_ready),
                        32'(data_in_1_valid && pending_words < 2));
            check_value("data_in_1_ready", 32'(data_in_1_ready),
                        32'(data_in_0_valid && pending_words < 2));
            check_value("data_out_0_valid", 32'(data_out_0_valid), 32'(pending_words != 0));
            if (data_out_0_valid && data_out_0_ready) begin
                if (pending_words == 0) begin
                    other_errors++;
                    $display("Output transfer seen while the model held no word");
                end else begin
                    for (int i = 0; i < lanes; i++) begin
                        expected = expect_q.pop_front();
                        check_value($sformatf("data_out_0[%0d]", i),
                                    {{(32-out_width){1'b0}}, data_out_0[i]},
                                    {{(32-out_width){1'b0}}, expected});
                    end
                    pending_words--;
                end
                out_count++;
            end
            if (data_in_0_valid && data_in_0_ready && data_in_1_valid && data_in_1_ready) begin
                for (int i = 0; i < lanes; i++) begin
                    expect_q.push_back(expected_lane(data_in_0[i], data_in_1[i]));
                end
                pending_words++;
                join_count++;
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the streams stopped making progress",
                 watchdog_ns);
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks_done, value_errors, other_errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'h3f86));
        reset            = 1'b1;
        data_in_0_valid  = 1'b0;
        data_in_1_valid  = 1'b0;
        data_out_0_ready = 1'b0;
        for (int i = 0; i < lanes; i++) begin
            data_in_0[i] = '0;
            data_in_1[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle after reset with nothing offered yet
        repeat (3) begin
            @(negedge clk);
            check_value("data_out_0_valid", 32'(data_out_0_valid), 32'd0);
        end

        run_phase(500, 100, 100, 1'b0);
        run_phase(64, 100, 100, 1'b1);
        run_phase(500, 50, 100, 1'b0);
        run_phase(500, 60, 50, 1'b0);
        run_phase(436, 100, 25, 1'b0);

        // Drain until the DUT holds no word
        @(posedge clk);
        #1;
        data_out_0_ready = 1'b1;
        wait (!data_out_0_valid);
        repeat (4) @(posedge clk);

        check_value("output transfer count", 32'(out_count), 32'(join_count));
        if (expect_q.size() != 0) begin
            other_errors++;
            $display("Model queue still holds %0d lanes at the end", expect_q.size());
        end

        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks_done, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: source/fixed_adder.sv
module fixed_adder #(
    parameter int LANES     = fixed_point_pkg::default_lanes,
    parameter int IN_WIDTH  = fixed_point_pkg::default_in_width,
    parameter int IN_FRAC   = fixed_point_pkg::default_in_frac,
    parameter int OUT_WIDTH = fixed_point_pkg::default_out_width,
    parameter int OUT_FRAC  = fixed_point_pkg::default_out_frac
) (
    input  logic clk,
    input  logic reset,

    input  logic signed [IN_WIDTH-1:0]  data_in_0 [LANES-1:0],
    input  logic                        data_in_0_valid,
    output logic                        data_in_0_ready,

    input  logic signed [IN_WIDTH-1:0]  data_in_1 [LANES-1:0],
    input  logic                        data_in_1_valid,
    output logic                        data_in_1_ready,

    output logic signed [OUT_WIDTH-1:0] data_out_0 [LANES-1:0],
    output logic                        data_out_0_valid,
    input  logic                        data_out_0_ready
);

    // Rounded and saturated sums, ahead of the output registers
    logic signed [OUT_WIDTH-1:0] cast_data [LANES-1:0];

    // Load strobes from the sequencer
    logic load_main;
    logic load_skid;
    logic main_from_skid;

    // Handshake join and slice occupancy
    stream_join_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .data_in_0_valid (data_in_0_valid),
        .data_in_1_valid (data_in_1_valid),
        .data_in_0_ready (data_in_0_ready),
        .data_in_1_ready (data_in_1_ready),
        .data_out_0_ready(data_out_0_ready),
        .data_out_0_valid(data_out_0_valid),
        .load_main       (load_main),
        .load_skid       (load_skid),
        .main_from_skid  (main_from_skid)
    );

    fixed_sum_cast #(
        .LANES    (LANES),
        .IN_WIDTH (IN_WIDTH),
        .IN_FRAC  (IN_FRAC),
        .OUT_WIDTH(OUT_WIDTH),
        .OUT_FRAC (OUT_FRAC)
    ) u_sum_cast (
        .data_in_0(data_in_0),
        .data_in_1(data_in_1),
        .cast_data(cast_data)
    );

    // Two-entry slice keeps full rate under back-pressure
    output_slice_regs #(
        .LANES    (LANES),
        .OUT_WIDTH(OUT_WIDTH)
    ) u_slice (
        .clk           (clk),
        .cast_data     (cast_data),
        .load_main     (load_main),
        .load_skid     (load_skid),
        .main_from_skid(main_from_skid),
        .data_out_0    (data_out_0)
    );

endmodule

// File: source/output_slice_regs.sv
module output_slice_regs #(
    parameter int LANES     = fixed_point_pkg::default_lanes,
    parameter int OUT_WIDTH = fixed_point_pkg::default_out_width
) (
    input  logic clk,

    input  logic signed [OUT_WIDTH-1:0] cast_data [LANES-1:0],

    input  logic load_main,
    input  logic load_skid,
    input  logic main_from_skid,

    output logic signed [OUT_WIDTH-1:0] data_out_0 [LANES-1:0]
);

    logic signed [OUT_WIDTH-1:0] main_data [LANES-1:0];
    logic signed [OUT_WIDTH-1:0] skid_data [LANES-1:0];
    logic signed [OUT_WIDTH-1:0] main_next [LANES-1:0];

    // Main refills from skid when the older word moves up
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (main_from_skid) begin
                main_next[i] = skid_data[i];
            end else begin
                main_next[i] = cast_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_main) begin
            for (int i = 0; i < LANES; i++) begin
                main_data[i] <= main_next[i];
            end
        end
    end

    // Skid only ever takes a fresh word
    always_ff @(posedge clk) begin
        if (load_skid) begin
            for (int i = 0; i < LANES; i++) begin
                skid_data[i] <= cast_data[i];
            end
        end
    end

    assign data_out_0 = main_data;

endmodule

// File: source/fixed_sum_cast.sv
module fixed_sum_cast #(
    parameter int LANES     = fixed_point_pkg::default_lanes,
    parameter int IN_WIDTH  = fixed_point_pkg::default_in_width,
    parameter int IN_FRAC   = fixed_point_pkg::default_in_frac,
    parameter int OUT_WIDTH = fixed_point_pkg::default_out_width,
    parameter int OUT_FRAC  = fixed_point_pkg::default_out_frac
) (
    input  logic signed [IN_WIDTH-1:0]  data_in_0 [LANES-1:0],
    input  logic signed [IN_WIDTH-1:0]  data_in_1 [LANES-1:0],
    output logic signed [OUT_WIDTH-1:0] cast_data [LANES-1:0]
);

    // One extra bit holds the carry of the addition
    localparam int SUM_W = IN_WIDTH + 1;

    localparam int R_SHIFT = (IN_FRAC > OUT_FRAC) ? (IN_FRAC - OUT_FRAC) : 0;
    localparam int L_SHIFT = (OUT_FRAC > IN_FRAC) ? (OUT_FRAC - IN_FRAC) : 0;

    // Room for the rounding carry, the left shift and the output limits
    localparam int GROW_W = SUM_W + 1 + L_SHIFT;
    localparam int WORK_W = (GROW_W > OUT_WIDTH + 1) ? GROW_W : OUT_WIDTH + 1;

    localparam logic signed [WORK_W-1:0] OUT_MAX = (WORK_W'(1) << (OUT_WIDTH - 1)) - 1;
    localparam logic signed [WORK_W-1:0] OUT_MIN = -(WORK_W'(1) << (OUT_WIDTH - 1));

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic signed [SUM_W-1:0]  sum;
        logic signed [WORK_W-1:0] wide;
        logic signed [WORK_W-1:0] scaled;

        // Sign-extend both operands before adding
        assign sum = {data_in_0[i][IN_WIDTH-1], data_in_0[i]}
                   + {data_in_1[i][IN_WIDTH-1], data_in_1[i]};

        assign wide = sum;

        if (R_SHIFT > 0) begin : g_round
            // Half an output LSB, so the shift rounds half up
            localparam logic signed [WORK_W-1:0] HALF = WORK_W'(1) << (R_SHIFT - 1);

            logic signed [WORK_W-1:0] rounded;

            assign rounded = wide + HALF;
            assign scaled  = rounded >>> R_SHIFT;
        end else begin : g_widen
            assign scaled = wide <<< L_SHIFT;
        end

        // Clamp to the signed output range
        assign cast_data[i] = (scaled > OUT_MAX) ? OUT_MAX[OUT_WIDTH-1:0] :
                              (scaled < OUT_MIN) ? OUT_MIN[OUT_WIDTH-1:0] :
                              scaled[OUT_WIDTH-1:0];
    end

endmodule

// File: source/stream_join_ctrl.sv
module stream_join_ctrl (
    input  logic clk,
    input  logic reset,

    input  logic data_in_0_valid,
    input  logic data_in_1_valid,
    output logic data_in_0_ready,
    output logic data_in_1_ready,

    input  logic data_out_0_ready,
    output logic data_out_0_valid,

    output logic load_main,
    output logic load_skid,
    output logic main_from_skid
);

    import fixed_point_pkg::*;

    slice_state_t state;
    slice_state_t state_next;

    logic room;
    logic accept;
    logic out_xfer;

    // Slice can take a word unless both entries are held
    assign room = (state != slice_two);

    // Each side waits on the other side's valid
    assign data_in_0_ready = data_in_1_valid & room;
    assign data_in_1_ready = data_in_0_valid & room;

    assign accept   = data_in_0_valid & data_in_1_valid & room;
    assign data_out_0_valid = (state != slice_empty);
    assign out_xfer = data_out_0_valid & data_out_0_ready;

    always_comb begin
        state_next     = state;
        load_main      = 1'b0;
        load_skid      = 1'b0;
        main_from_skid = 1'b0;

        case (state)
            slice_empty: begin
                if (accept) begin
                    load_main  = 1'b1;
                    state_next = slice_one;
                end
            end
            slice_one: begin
                if (accept && out_xfer) begin
                    // Main drains and refills at the same edge
                    load_main = 1'b1;
                end else if (accept) begin
                    load_skid  = 1'b1;
                    state_next = slice_two;
                end else if (out_xfer) begin
                    state_next = slice_empty;
                end
            end
            slice_two: begin
                // No accept possible here, only the skid word moves up
                if (out_xfer) begin
                    load_main      = 1'b1;
                    main_from_skid = 1'b1;
                    state_next     = slice_one;
                end
            end
            default: begin
                state_next = slice_empty;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= slice_empty;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: source/fixed_point_pkg.sv
package fixed_point_pkg;

    // Lanes carried by one beat of each stream
    localparam int default_lanes = 4;

    // Input format, shared by both operands
    localparam int default_in_width = 16;
    localparam int default_in_frac  = 3;

    // Output format after rounding and saturation
    localparam int default_out_width = 12;
    localparam int default_out_frac  = 2;

    // Occupancy of the two-entry output slice
    typedef enum logic [1:0] {
        slice_empty = 2'b00,
        slice_one   = 2'b01,
        slice_two   = 2'b10
    } slice_state_t;

endpackage
